//--- sources.f
+incdir+source
source/time_sync_pkg.sv
source/host_cmd_decoder.sv
source/cmd_fifo.sv
source/time_mgr.sv
source/time_sync_top.sv
tests/time_sync_tb.sv

//--- tests/time_sync_tb.sv
`timescale 1ns/1ps
`include "time_sync_config.svh"

module time_sync_tb;

  // host address map
  localparam logic [2:0] ADR_DATA   = 3'd0;
  localparam logic [2:0] ADR_WAIT   = 3'd1;
  localparam logic [2:0] ADR_HOST   = 3'd2;
  localparam logic [2:0] ADR_RESET  = 3'd3;
  localparam logic [2:0] ADR_UNIT   = 3'd4;
  localparam logic [2:0] ADR_EPOCH  = 3'd5;
  localparam logic [2:0] ADR_EPOCHS = 3'd6;
  localparam logic [2:0] ADR_LEVEL  = 3'd7;
  localparam logic [31:0] SEED      = 32'h8289;
  // unit length used by the heartbeat and wait tests
  localparam int UNIT_LEN = 4;
  // per-test cycle budgets plus margin
  localparam int MAX_CYCLES = 200 + 300 + 200 + 200 + 150 + 250;

  logic                  clk;
  logic                  reset;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [2:0]            wb_adr;
  logic [`TS_DATA_W-1:0] wb_dat_w;
  logic [`TS_DATA_W-1:0] wb_dat_r;
  logic                  wb_ack;
  logic                  hb_valid;
  logic [`TS_TIME_W-1:0] hb_epoch;
  logic                  hb_ack;
  logic                  dn_valid;
  logic [`TS_DATA_W-1:0] dn_data;
  logic                  dn_ready;
  logic                  stall_dn;
  logic                  squash_dn;

  logic [31:0]           lfsr;
  logic [31:0]           exp_q [$];
  logic                  ready_random;
  logic                  hb_track;
  logic                  stall_prev;
  logic                  stall_seen;
  logic [`TS_TIME_W-1:0] hb_prev;
  logic [`TS_TIME_W-1:0] last_hb;
  int                    hb_count;
  int                    cycles;
  int                    timeout_cnt;
  int                    roll_cycle;
  int                    fall_cycle;
  int                    dn_cycle;
  int                    stall_cycles;
  int                    checks;
  int                    errors;
  int                    test_err_base;
  int                    tests_done;
  int                    tests_failed;

  time_sync_top time_sync_top_inst (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .hb_valid  (hb_valid),
    .hb_epoch  (hb_epoch),
    .hb_ack    (hb_ack),
    .dn_valid  (dn_valid),
    .dn_data   (dn_data),
    .dn_ready  (dn_ready),
    .stall_dn  (stall_dn),
    .squash_dn (squash_dn)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // takes n bits msb first with one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond)
    else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_done++;
    if (errors == test_err_base) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: %0d error(s)", name, errors - test_err_base);
      tests_failed++;
    end
    test_err_base = errors;
  endtask

  // drives one request from a falling edge
  task automatic wb_begin(input bit we, input logic [2:0] adr, input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
  endtask

  // waits for ack on falling edges and then ends the cycle
  task automatic wb_end(input int limit, output logic [31:0] rdata);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < limit);
    check_true(wb_ack, $sformatf("no wb_ack within %0d cycles", limit));
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_begin(1'b1, adr, data);
    wb_end(100, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdata);
    wb_begin(1'b0, adr, '0);
    wb_end(100, rdata);
  endtask

  // wait until every expected word has left on dn_data
  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    check_true(exp_q.size() == 0, "expected words were not delivered in time");
  endtask

  // random dn_ready only while the main thread leaves the lfsr alone
  always @(negedge clk) begin
    if (ready_random) begin
      dn_ready = (take_bits(1) != '0);
    end
  end

  always @(posedge clk) begin
    timeout_cnt++;
    if (timeout_cnt >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", timeout_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // output monitor sampled on the rising edge
  always @(posedge clk) begin
    if (!reset) begin
      cycles++;
      if (stall_dn) begin
        stall_cycles++;
        stall_seen = 1'b1;
        check_true(!dn_valid, "dn_valid was high while stall_dn was high");
      end
      if (stall_prev && !stall_dn) begin
        fall_cycle = cycles;
      end
      stall_prev = stall_dn;
      // words must leave in write order
      if (dn_valid && dn_ready) begin
        dn_cycle = cycles;
        if (exp_q.size() == 0) begin
          check_true(1'b0, "a word appeared on dn_data that was never written");
        end else begin
          check_val("dn_data", dn_data, exp_q.pop_front());
        end
      end
      // expected heartbeat count advances by one per transfer
      if (hb_track && hb_valid && hb_ack) begin
        check_val("hb_epoch", hb_epoch, last_hb + 1);
        last_hb = last_hb + 1;
        hb_count++;
      end
      // each rollover moves hb_epoch
      if (hb_track && hb_epoch !== hb_prev) begin
        if (roll_cycle != 0) begin
          check_val("rollover_spacing", cycles - roll_cycle, UNIT_LEN * 4);
        end
        roll_cycle = cycles;
      end
      hb_prev = hb_epoch;
    end
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] d;
    logic [31:0] words [16];
    int n;
    int wlen;
    clk = 1'b0;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    hb_ack = 1'b1;
    dn_ready = 1'b1;
    lfsr = SEED;
    ready_random = 1'b0;
    hb_track = 1'b0;
    stall_prev = 1'b0;
    stall_seen = 1'b0;
    last_hb = '0;
    hb_count = 0;
    cycles = 0;
    timeout_cnt = 0;
    roll_cycle = 0;
    fall_cycle = 0;
    dn_cycle = 0;
    stall_cycles = 0;
    checks = 0;
    errors = 0;
    test_err_base = 0;
    tests_done = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // heartbeats every 16 clocks acked after a random delay
    wb_write(ADR_UNIT, UNIT_LEN);
    wb_write(ADR_EPOCH, 4);
    wb_write(ADR_RESET, 0);
    // let any heartbeat from before the time reset drain
    repeat (4) @(negedge clk);
    hb_track = 1'b1;
    hb_ack = 1'b0;
    repeat (5) begin
      n = 0;
      while (!hb_valid && n < 40) begin
        @(negedge clk);
        n++;
      end
      check_true(hb_valid, "no heartbeat within 40 cycles");
      repeat (take_bits(3)) @(negedge clk);
      hb_ack = 1'b1;
      @(negedge clk);
      hb_ack = 1'b0;
    end
    wb_read(ADR_EPOCHS, rd);
    check_true(rd == last_hb || rd == last_hb + 1,
      $sformatf("epoch read %0d is not the last heartbeat %0d or one more", rd, last_hb));
    check_val("hb_count", hb_count, 5);
    hb_track = 1'b0;
    hb_ack = 1'b1;
    end_test("1 heartbeat");

    // slow epochs and a host that is caught up keep the stream running
    wb_write(ADR_EPOCH, 1000);
    wb_write(ADR_RESET, 0);
    wb_write(ADR_HOST, 0);
    for (int i = 0; i < 16; i++) begin
      words[i] = take_bits(32);
    end
    @(posedge clk);
    ready_random = 1'b1;
    @(negedge clk);
    for (int i = 0; i < 16; i++) begin
      exp_q.push_back(words[i]);
      wb_write(ADR_DATA, words[i]);
    end
    wait_drain(200);
    @(posedge clk);
    ready_random = 1'b0;
    @(negedge clk);
    dn_ready = 1'b1;
    end_test("2 data ordering");

    // wait of 1 to 4 units holds the following word
    repeat (3) begin
      wlen = take_bits(2) + 1;
      d = take_bits(32);
      stall_cycles = 0;
      fall_cycle = 0;
      wb_write(ADR_WAIT, wlen);
      exp_q.push_back(d);
      wb_write(ADR_DATA, d);
      wait_drain(60);
      check_true(stall_cycles >= (wlen - 1) * UNIT_LEN && stall_cycles <= wlen * UNIT_LEN + 2,
        $sformatf("stall lasted %0d cycles for a wait of %0d units", stall_cycles, wlen));
      check_true(fall_cycle != 0 && dn_cycle >= fall_cycle,
        "data word left before the stall ended");
    end
    end_test("3 wait stall");

    // fast epochs with the host left behind
    wb_write(ADR_UNIT, 2);
    wb_write(ADR_EPOCH, 2);
    n = 0;
    while (!squash_dn && n < 40) begin
      @(negedge clk);
      n++;
    end
    check_true(squash_dn, "squash_dn did not rise while the host epoch lagged");
    stall_seen = 1'b0;
    repeat (2) begin
      d = take_bits(32);
      wb_write(ADR_WAIT, 3);
      exp_q.push_back(d);
      wb_write(ADR_DATA, d);
    end
    wait_drain(40);
    check_true(!stall_seen, "stall_dn rose for a wait while squashing");
    // freeze the epoch count, then report it as the host epoch
    wb_write(ADR_EPOCH, 1000);
    wb_read(ADR_EPOCHS, rd);
    wb_write(ADR_HOST, rd);
    n = 0;
    while (squash_dn && n < 10) begin
      @(negedge clk);
      n++;
    end
    check_true(!squash_dn, "squash_dn stayed high after the host caught up");
    end_test("4 squash");

    // fill the fifo behind a blocked stream
    dn_ready = 1'b0;
    for (int i = 0; i < `TS_FIFO_DEPTH; i++) begin
      d = take_bits(32);
      exp_q.push_back(d);
      wb_write(ADR_DATA, d);
    end
    wb_read(ADR_LEVEL, rd);
    check_val("wb_dat_r", rd, `TS_FIFO_DEPTH);
    d = take_bits(32);
    exp_q.push_back(d);
    wb_begin(1'b1, ADR_DATA, d);
    n = 0;
    repeat (10) begin
      @(negedge clk);
      if (wb_ack) begin
        n++;
      end
    end
    check_true(n == 0, "a write was acked while the fifo was full");
    dn_ready = 1'b1;
    wb_end(20, rd);
    wait_drain(40);
    end_test("5 back-pressure");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
      tests_done, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- source/time_sync_top.sv
`timescale 1ns/1ps
`include "time_sync_config.svh"

module time_sync_top
  import time_sync_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // host wishbone port
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [2:0]            wb_adr,
  input  logic [`TS_DATA_W-1:0] wb_dat_w,
  output logic [`TS_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  // heartbeat to the host
  output logic                  hb_valid,
  output logic [`TS_TIME_W-1:0] hb_epoch,
  input  logic                  hb_ack,
  // downstream stream
  output logic                  dn_valid,
  output logic [`TS_DATA_W-1:0] dn_data,
  input  logic                  dn_ready,
  output logic                  stall_dn,
  output logic                  squash_dn
);

  logic                  push;
  ts_cmd_t               push_cmd;
  logic                  full;
  logic                  pop;
  logic                  head_valid;
  ts_cmd_t               head;
  logic [3:0]            level;
  logic [`TS_TIME_W-1:0] epochs;
  ts_cfg_t               cfg;

  host_cmd_decoder host_cmd_decoder_inst (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .push     (push),
    .push_cmd (push_cmd),
    .full     (full),
    .level    (level),
    .epochs   (epochs),
    .cfg      (cfg)
  );

  cmd_fifo #(
    .DEPTH (`TS_FIFO_DEPTH)
  ) cmd_fifo_inst (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_cmd   (push_cmd),
    .full       (full),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head),
    .level      (level)
  );

  time_mgr time_mgr_inst (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .epochs     (epochs),
    .hb_valid   (hb_valid),
    .hb_epoch   (hb_epoch),
    .hb_ack     (hb_ack),
    .dn_valid   (dn_valid),
    .dn_data    (dn_data),
    .dn_ready   (dn_ready),
    .stall_dn   (stall_dn),
    .squash_dn  (squash_dn)
  );

endmodule

//--- source/time_mgr.sv
`timescale 1ns/1ps
`include "time_sync_config.svh"

module time_mgr
  import time_sync_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  ts_cfg_t               cfg,
  input  logic                  head_valid,
  input  ts_cmd_t               head,
  output logic                  pop,
  output logic [`TS_TIME_W-1:0] epochs,
  output logic                  hb_valid,
  output logic [`TS_TIME_W-1:0] hb_epoch,
  input  logic                  hb_ack,
  output logic                  dn_valid,
  output logic [`TS_DATA_W-1:0] dn_data,
  input  logic                  dn_ready,
  output logic                  stall_dn,
  output logic                  squash_dn
);

  localparam logic [`TS_EPOCH_W-1:0] UNIT_ONE   = 1;
  localparam logic [`TS_TIME_W:0]    SQUASH_THR = `TS_SQUASH_THR;

  // clocks into the current unit
  logic [`TS_UNIT_W-1:0]  unit_cnt;
  logic                   unit_pulse;
  // units into the current epoch, 1 to epoch_len
  logic [`TS_EPOCH_W-1:0] units;
  logic                   rollover;
  // last epoch count reported by the host
  logic [`TS_TIME_W-1:0]  host_epoch;
  // units left in the current wait
  logic [`TS_EPOCH_W-1:0] wait_cnt;
  dn_state_t              state;
  logic                   behind;
  logic                   is_data;
  logic                   is_wait;
  logic                   is_host;
  logic                   is_rst;
  logic                   take_wait;

  // head decode
  assign is_data = head_valid & (head.op == OP_DATA);
  assign is_wait = head_valid & (head.op == OP_WAIT);
  assign is_host = head_valid & (head.op == OP_HOST_EPOCH);
  assign is_rst  = head_valid & (head.op == OP_RESET_TIME);

  // free running unit pulser
  // a unit_len of 0 or 1 pulses every clock
  assign unit_pulse = ({1'b0, unit_cnt} + 1'b1) >= {1'b0, cfg.unit_len};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      unit_cnt <= '0;
    end else if (is_rst | unit_pulse) begin
      unit_cnt <= '0;
    end else begin
      unit_cnt <= unit_cnt + 1'b1;
    end
  end

  // epoch rolls on the pulse that ends unit epoch_len
  assign rollover = unit_pulse & (units >= cfg.epoch_len) & ~is_rst;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      epochs <= '0;
      units  <= '0;
    end else if (is_rst) begin
      epochs <= '0;
      units  <= UNIT_ONE;
    end else if (rollover) begin
      epochs <= epochs + 1'b1;
      units  <= UNIT_ONE;
    end else if (unit_pulse) begin
      units <= units + 1'b1;
    end
  end

  // at most one heartbeat pending
  // a newer rollover replaces the pending count
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hb_valid <= 1'b0;
    end else if (rollover) begin
      hb_valid <= 1'b1;
    end else if (hb_ack) begin
      hb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rollover) begin
      hb_epoch <= epochs + 1'b1;
    end
  end

  // host progress
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      host_epoch <= '0;
    end else if (is_host) begin
      host_epoch <= head.arg[`TS_TIME_W-1:0];
    end
  end

  // extra bit so the threshold add cannot wrap
  assign behind = {1'b0, epochs} > ({1'b0, host_epoch} + SQUASH_THR);

  // a wait is consumed in squash, or in run when no squash is due
  assign take_wait = is_wait & ((state == DN_SQUASH) | ((state == DN_RUN) & ~behind));

  // downstream outputs
  assign stall_dn  = (state == DN_STALL);
  assign squash_dn = (state == DN_SQUASH);
  assign dn_valid  = is_data & (state != DN_STALL);
  assign dn_data   = head.arg;

  // epoch and time-reset commands never wait, data leaves on transfer
  assign pop = is_host | is_rst | take_wait | (dn_valid & dn_ready);

  // run/stall/squash machine
  // the pulser is not restarted by a wait, so a wait can come up
  // to one unit short and software has to budget for that
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= DN_RUN;
      wait_cnt <= '0;
    end else begin
      case (state)
        DN_RUN: begin
          if (behind) begin
            state <= DN_SQUASH;
          end else if (is_wait) begin
            state    <= DN_STALL;
            wait_cnt <= head.arg[`TS_EPOCH_W-1:0];
          end
        end
        DN_STALL: begin
          if (wait_cnt == '0) begin
            state <= DN_RUN;
          end else if (unit_pulse) begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        DN_SQUASH: begin
          wait_cnt <= '0;
          if (!behind) begin
            state <= DN_RUN;
          end
        end
        default: begin
          state    <= DN_RUN;
          wait_cnt <= '0;
        end
      endcase
    end
  end

  // a wait always runs out before run is entered again
  a_run_no_wait: assert property (@(posedge clk) disable iff (reset)
    (state == DN_RUN) |-> (wait_cnt == '0))
    else $error("wait countdown left over in run");

endmodule

//--- source/cmd_fifo.sv
`timescale 1ns/1ps
`include "time_sync_config.svh"

module cmd_fifo
  import time_sync_pkg::*;
#(
  parameter int DEPTH = `TS_FIFO_DEPTH
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    push,
  input  ts_cmd_t push_cmd,
  output logic    full,
  input  logic    pop,
  output logic    head_valid,
  output ts_cmd_t head,
  output logic [3:0] level
);

  // depth is a power of two of at least 2, so pointers wrap by themselves
  localparam int PTR_W = $clog2(DEPTH);

  ts_cmd_t           mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  // one bit wider than the pointers to hold a full count
  logic [PTR_W:0]    count;

  assign full       = (count == (PTR_W+1)'(DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign level      = 4'(count);

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push & ~pop) begin
        count <= count + 1'b1;
      end else if (pop & ~push) begin
        count <= count - 1'b1;
      end
    end
  end

  // the decoder must respect full
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("push into a full command fifo");

  // the time manager must only pop a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> head_valid)
    else $error("pop from an empty command fifo");

endmodule

//--- source/host_cmd_decoder.sv
`timescale 1ns/1ps
`include "time_sync_config.svh"

module host_cmd_decoder
  import time_sync_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [2:0]             wb_adr,
  input  logic [`TS_DATA_W-1:0]  wb_dat_w,
  output logic [`TS_DATA_W-1:0]  wb_dat_r,
  output logic                   wb_ack,
  output logic                   push,
  output ts_cmd_t                push_cmd,
  input  logic                   full,
  input  logic [3:0]             level,
  input  logic [`TS_TIME_W-1:0]  epochs,
  output ts_cfg_t                cfg
);

  // config and status addresses, 0 to 3 are commands
  localparam logic [2:0] ADR_UNIT_LEN  = 3'd4;
  localparam logic [2:0] ADR_EPOCH_LEN = 3'd5;
  localparam logic [2:0] ADR_EPOCHS    = 3'd6;
  localparam logic [2:0] ADR_LEVEL     = 3'd7;

  logic req;
  logic cmd_wr;

  // new request, the ack cycle itself is not a request
  assign req = wb_cyc & wb_stb & ~wb_ack;

  // a write to the lower half of the map is a command
  assign cmd_wr = req & wb_we & ~wb_adr[2];

  // push only into a fifo with room, otherwise the write waits
  assign push = cmd_wr & ~full;

  always_comb begin
    push_cmd.arg = wb_dat_w;
    case (wb_adr[1:0])
      2'd0: push_cmd.op = OP_DATA;
      2'd1: push_cmd.op = OP_WAIT;
      2'd2: push_cmd.op = OP_HOST_EPOCH;
      default: push_cmd.op = OP_RESET_TIME;
    endcase
  end

  // ack one cycle after the request, held off while a command meets a full fifo
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req & ~(cmd_wr & full);
    end
  end

  // config registers take effect as soon as they are written
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg <= '0;
    end else if (req & wb_we) begin
      if (wb_adr == ADR_UNIT_LEN) begin
        cfg.unit_len <= wb_dat_w[`TS_UNIT_W-1:0];
      end
      if (wb_adr == ADR_EPOCH_LEN) begin
        cfg.epoch_len <= wb_dat_w[`TS_EPOCH_W-1:0];
      end
    end
  end

  // read data lines up with the ack
  // only the two status addresses return something
  always_ff @(posedge clk) begin
    if (req & ~wb_we) begin
      case (wb_adr)
        ADR_EPOCHS: wb_dat_r <= epochs;
        ADR_LEVEL:  wb_dat_r <= {{(`TS_DATA_W-4){1'b0}}, level};
        default:    wb_dat_r <= '0;
      endcase
    end
  end

  // every transfer gets a single-cycle ack
  a_ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for more than one cycle");

endmodule

//--- source/time_sync_pkg.sv
`include "time_sync_config.svh"

package time_sync_pkg;

  // command opcodes
  // encoding follows the low two bits of the host address map
  typedef enum logic [1:0] {
    OP_DATA       = 2'd0,
    OP_WAIT       = 2'd1,
    OP_HOST_EPOCH = 2'd2,
    OP_RESET_TIME = 2'd3
  } cmd_op_t;

  // one command record as it sits in the fifo
  typedef struct packed {
    cmd_op_t               op;
    logic [`TS_DATA_W-1:0] arg;
  } ts_cmd_t;

  // timing configuration written by the host
  typedef struct packed {
    // clocks per unit
    logic [`TS_UNIT_W-1:0]  unit_len;
    // units per epoch
    logic [`TS_EPOCH_W-1:0] epoch_len;
  } ts_cfg_t;

  // downstream control states
  // run passes data, stall holds it for a wait,
  // squash drops waits while the host is behind
  typedef enum logic [1:0] {
    DN_RUN    = 2'd0,
    DN_STALL  = 2'd1,
    DN_SQUASH = 2'd2
  } dn_state_t;

endpackage

//--- source/time_sync_config.svh
`ifndef TIME_SYNC_CONFIG_SVH
`define TIME_SYNC_CONFIG_SVH

// wishbone data word and command argument width
`define TS_DATA_W 32

// unit length in clocks
`define TS_UNIT_W 16

// epoch length and wait count, both in units
`define TS_EPOCH_W 10

// epoch counter width
`define TS_TIME_W 32

// command slots in the fifo, power of two
`define TS_FIFO_DEPTH 8

// epochs the host may fall behind before waits get squashed
`define TS_SQUASH_THR 1

`endif
